// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_pkg.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/issue_unit.sv
      - logic/reg_file.sv
      - logic/alu_unit.sv
      - logic/out_port_unit.sv
      - logic/cpu_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cpu_core_assert.sv
      - tests/cpu_core_tb.sv

// File: build.f
+incdir+include
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/issue_unit.sv
logic/reg_file.sv
logic/alu_unit.sv
logic/out_port_unit.sv
logic/cpu_core.sv
tests/cpu_core_assert.sv
tests/cpu_core_tb.sv

// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and register file
`define CPU_XLEN 32
`define CPU_NREGS 32
`define CPU_REG_AW 5

// one address per 64-bit bundle
`define CPU_BUNDLE_AW 12

// opcodes, bits 31:26
`define CPU_OP_ALU 6'h01
`define CPU_OP_ADDI 6'h02
`define CPU_OP_OUT 6'h03
`define CPU_OP_J 6'h04

// register form function codes, bits 2:0
`define CPU_FN_ADD 3'd0
`define CPU_FN_SUB 3'd1
`define CPU_FN_AND 3'd2
`define CPU_FN_OR 3'd3
`define CPU_FN_XOR 3'd4

`endif

// File: logic/alu_unit.sv
`include "cpu_settings.svh"

module alu_unit import cpu_pkg::*; (
	input logic i_vld,
	input alu_fn_t i_fn,
	input word_t i_a,
	input word_t i_b,
	input reg_addr_t i_dd,
	output logic o_we,
	output reg_addr_t o_waddr,
	output word_t o_wdata
);

	// result is seen by forwarding this cycle, written at the next edge
	assign o_we = i_vld;
	assign o_waddr = i_dd;

	always_comb begin
		case (i_fn)
			`CPU_FN_ADD: o_wdata = i_a + i_b;
			`CPU_FN_SUB: o_wdata = i_a - i_b;
			`CPU_FN_AND: o_wdata = i_a & i_b;
			`CPU_FN_OR: o_wdata = i_a | i_b;
			`CPU_FN_XOR: o_wdata = i_a ^ i_b;
			default: o_wdata = '0;
		endcase
	end

endmodule

// File: logic/cpu_core.sv
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic [2*`CPU_XLEN-1:0] i_rdata,
	input logic i_io_out_rdy,
	output bundle_addr_t o_i_addr,
	output logic [7:0] o_io_out_data,
	output logic o_io_out_vld
);

	logic stall;
	logic hold_slot1;
	logic jump_en;
	bundle_addr_t jump_target;
	logic [1:0] slot_vld;
	instr_u instr0;
	instr_u instr1;
	logic [1:0] dec_vld;
	reg_addr_t [3:0] rd_addr;
	word_t [3:0] rd_data;
	logic [1:0] alu_vld;
	alu_fn_t [1:0] alu_fn;
	word_t [1:0] alu_a;
	word_t [1:0] alu_b;
	reg_addr_t [1:0] alu_dd;
	logic [1:0] wb_we;
	reg_addr_t [1:0] wb_waddr;
	word_t [1:0] wb_wdata;
	logic out_en;
	logic [7:0] out_byte;
	logic out_busy;

	fetch_unit u_fetch (
		.clk(clk),
		.rstn(rstn),
		.i_stall(stall),
		.i_jump_en(jump_en),
		.i_jump_target(jump_target),
		.o_addr(o_i_addr),
		.o_slot_vld(slot_vld)
	);

	decode_unit u_decode (
		.clk(clk),
		.rstn(rstn),
		.i_bundle(i_rdata),
		.i_slot_vld(slot_vld),
		.i_stall(stall),
		.i_hold_slot1(hold_slot1),
		.o_instr0(instr0),
		.o_instr1(instr1),
		.o_vld(dec_vld),
		.o_jump_en(jump_en),
		.o_jump_target(jump_target)
	);

	issue_unit u_issue (
		.clk(clk),
		.rstn(rstn),
		.i_instr0(instr0),
		.i_instr1(instr1),
		.i_vld(dec_vld),
		.i_out_busy(out_busy),
		.i_rd_data(rd_data),
		.o_rd_addr(rd_addr),
		.o_stall(stall),
		.o_hold_slot1(hold_slot1),
		.o_alu_vld(alu_vld),
		.o_alu_fn(alu_fn),
		.o_alu_a(alu_a),
		.o_alu_b(alu_b),
		.o_alu_dd(alu_dd),
		.o_out_en(out_en),
		.o_out_byte(out_byte)
	);

	reg_file u_regs (
		.clk(clk),
		.i_we(wb_we),
		.i_waddr(wb_waddr),
		.i_wdata(wb_wdata),
		.i_raddr(rd_addr),
		.o_rdata(rd_data)
	);

	// slot 0 work on alu0, slot 1 work on alu1
	alu_unit u_alu0 (
		.i_vld(alu_vld[0]),
		.i_fn(alu_fn[0]),
		.i_a(alu_a[0]),
		.i_b(alu_b[0]),
		.i_dd(alu_dd[0]),
		.o_we(wb_we[0]),
		.o_waddr(wb_waddr[0]),
		.o_wdata(wb_wdata[0])
	);

	alu_unit u_alu1 (
		.i_vld(alu_vld[1]),
		.i_fn(alu_fn[1]),
		.i_a(alu_a[1]),
		.i_b(alu_b[1]),
		.i_dd(alu_dd[1]),
		.o_we(wb_we[1]),
		.o_waddr(wb_waddr[1]),
		.o_wdata(wb_wdata[1])
	);

	out_port_unit u_out (
		.clk(clk),
		.rstn(rstn),
		.i_en(out_en),
		.i_byte(out_byte),
		.i_io_out_rdy(i_io_out_rdy),
		.o_io_out_data(o_io_out_data),
		.o_io_out_vld(o_io_out_vld),
		.o_busy(out_busy)
	);

endmodule

// File: logic/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_REG_AW-1:0] reg_addr_t;
	typedef logic [`CPU_BUNDLE_AW-1:0] bundle_addr_t;
	typedef logic [2:0] alu_fn_t;

	// register form
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t dd;
		reg_addr_t ds;
		reg_addr_t dt;
		logic [7:0] spare;
		alu_fn_t fn;
	} instr_r_t;

	// immediate form, shares opcode/dd/ds with the register form
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t dd;
		reg_addr_t ds;
		logic [15:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

// File: logic/decode_unit.sv
`include "cpu_settings.svh"

module decode_unit import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic [2*`CPU_XLEN-1:0] i_bundle,
	input logic [1:0] i_slot_vld,
	input logic i_stall,
	input logic i_hold_slot1,
	output instr_u o_instr0,
	output instr_u o_instr1,
	output logic [1:0] o_vld,
	output logic o_jump_en,
	output bundle_addr_t o_jump_target
);

	instr_u skid0;
	instr_u skid1;
	logic [1:0] skid_vld;
	logic skid_full;
	instr_u src0;
	instr_u src1;
	logic [1:0] src_vld;
	logic [1:0] is_jump;

	// a parked bundle goes ahead of the one on the bus
	assign src0 = skid_full ? skid0 : i_bundle[2*`CPU_XLEN-1:`CPU_XLEN];
	assign src1 = skid_full ? skid1 : i_bundle[`CPU_XLEN-1:0];
	assign src_vld = skid_full ? skid_vld : i_slot_vld;

	assign is_jump[0] = src_vld[0] & (src0.i.opcode == `CPU_OP_J);
	assign is_jump[1] = src_vld[1] & (src1.i.opcode == `CPU_OP_J);

	// redirect only when the jump bundle is really taken in
	assign o_jump_en = ~i_stall & (|is_jump);
	assign o_jump_target = is_jump[0] ? src0.i.imm[`CPU_BUNDLE_AW-1:0]
		: src1.i.imm[`CPU_BUNDLE_AW-1:0];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_vld <= '0;
			skid_vld <= '0;
			skid_full <= 1'b0;
		end else if (i_stall) begin
			// held slot 1 moves down and issues alone
			if (i_hold_slot1) begin
				o_vld <= {1'b0, o_vld[1]};
			end
			if (!skid_full) begin
				skid_vld <= i_slot_vld;
				skid_full <= 1'b1;
			end
		end else begin
			o_vld <= {src_vld[1] & ~is_jump[0], src_vld[0]};
			skid_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_stall) begin
			if (i_hold_slot1) begin
				o_instr0 <= o_instr1;
			end
			if (!skid_full) begin
				skid0 <= i_bundle[2*`CPU_XLEN-1:`CPU_XLEN];
				skid1 <= i_bundle[`CPU_XLEN-1:0];
			end
		end else begin
			o_instr0 <= src0;
			o_instr1 <= src1;
		end
	end

endmodule

// File: logic/fetch_unit.sv
module fetch_unit import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic i_stall,
	input logic i_jump_en,
	input bundle_addr_t i_jump_target,
	output bundle_addr_t o_addr,
	output logic [1:0] o_slot_vld
);

	// the bundle on the bus next cycle must be dropped
	logic squash;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_addr <= '0;
			// memory answered the reset-time address, which repeats right after
			squash <= 1'b1;
		end else begin
			squash <= i_jump_en;
			if (i_jump_en) begin
				o_addr <= i_jump_target;
			end else if (!i_stall) begin
				o_addr <= o_addr + 1'b1;
			end
		end
	end

	// slot 1 behind a jump in slot 0 is killed later in decode
	assign o_slot_vld = {2{~squash}};

endmodule

// File: logic/issue_unit.sv
`include "cpu_settings.svh"

module issue_unit import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input instr_u i_instr0,
	input instr_u i_instr1,
	input logic [1:0] i_vld,
	input logic i_out_busy,
	input word_t [3:0] i_rd_data,
	output reg_addr_t [3:0] o_rd_addr,
	output logic o_stall,
	output logic o_hold_slot1,
	output logic [1:0] o_alu_vld,
	output alu_fn_t [1:0] o_alu_fn,
	output word_t [1:0] o_alu_a,
	output word_t [1:0] o_alu_b,
	output reg_addr_t [1:0] o_alu_dd,
	output logic o_out_en,
	output logic [7:0] o_out_byte
);

	instr_u slot [2];
	logic [1:0] is_alu;
	logic [1:0] is_addi;
	logic [1:0] is_out;
	logic [1:0] rd_ds;
	logic [1:0] rd_dt;
	logic [1:0] issue;
	logic dep;
	logic stall0;
	word_t [1:0] op_b;

	assign slot[0] = i_instr0;
	assign slot[1] = i_instr1;

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			is_alu[k] = slot[k].r.opcode == `CPU_OP_ALU;
			is_addi[k] = slot[k].i.opcode == `CPU_OP_ADDI;
			is_out[k] = slot[k].r.opcode == `CPU_OP_OUT;
			rd_ds[k] = is_alu[k] | is_addi[k] | is_out[k];
			rd_dt[k] = is_alu[k];
			op_b[k] = is_addi[k]
				? {{(`CPU_XLEN-16){slot[k].i.imm[15]}}, slot[k].i.imm}
				: i_rd_data[2*k+1];
		end
	end

	// ports 0/1 serve slot 0, ports 2/3 slot 1
	assign o_rd_addr[0] = slot[0].r.ds;
	assign o_rd_addr[1] = slot[0].r.dt;
	assign o_rd_addr[2] = slot[1].r.ds;
	assign o_rd_addr[3] = slot[1].r.dt;

	// only hazard left: slot 1 reads what slot 0 writes
	assign dep = (is_alu[0] | is_addi[0]) & (slot[0].r.dd != '0)
		& ((rd_ds[1] & (slot[1].r.ds == slot[0].r.dd))
		| (rd_dt[1] & (slot[1].r.dt == slot[0].r.dd)));

	assign issue[0] = i_vld[0] & ~(is_out[0] & i_out_busy);
	assign stall0 = i_vld[0] & ~issue[0];
	assign issue[1] = i_vld[1] & issue[0] & ~dep & ~(is_out[0] & is_out[1])
		& ~(is_out[1] & i_out_busy);

	assign o_hold_slot1 = i_vld[1] & ~issue[1] & ~stall0;
	assign o_stall = stall0 | o_hold_slot1;

	// output unit has its own register, so vld rises one edge after issue
	assign o_out_en = (issue[0] & is_out[0]) | (issue[1] & is_out[1]);
	assign o_out_byte = (issue[0] & is_out[0]) ? i_rd_data[0][7:0] : i_rd_data[2][7:0];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_alu_vld <= '0;
		end else begin
			o_alu_vld <= issue & (is_alu | is_addi);
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < 2; k++) begin
			o_alu_fn[k] <= is_addi[k] ? `CPU_FN_ADD : slot[k].r.fn;
			o_alu_a[k] <= i_rd_data[2*k];
			o_alu_b[k] <= op_b[k];
			o_alu_dd[k] <= slot[k].r.dd;
		end
	end

endmodule

// File: logic/out_port_unit.sv
module out_port_unit (
	input logic clk,
	input logic rstn,
	input logic i_en,
	input logic [7:0] i_byte,
	input logic i_io_out_rdy,
	output logic [7:0] o_io_out_data,
	output logic o_io_out_vld,
	output logic o_busy
);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_io_out_vld <= 1'b0;
		end else if (i_en) begin
			o_io_out_vld <= 1'b1;
		end else if (i_io_out_rdy) begin
			o_io_out_vld <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_en) begin
			o_io_out_data <= i_byte;
		end
	end

	// a new byte may load in the same cycle the old one is taken
	assign o_busy = o_io_out_vld & ~i_io_out_rdy;

endmodule

// File: logic/reg_file.sv
`include "cpu_settings.svh"

module reg_file import cpu_pkg::*; (
	input logic clk,
	input logic [1:0] i_we,
	input reg_addr_t [1:0] i_waddr,
	input word_t [1:0] i_wdata,
	input reg_addr_t [3:0] i_raddr,
	output word_t [3:0] o_rdata
);

	word_t regs [`CPU_NREGS];

	// port 1 carries the later slot and wins on equal addresses
	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (i_we[w] && i_waddr[w] != '0) begin
				regs[i_waddr[w]] <= i_wdata[w];
			end
		end
	end

	always_comb begin
		for (int r = 0; r < 4; r++) begin
			if (i_raddr[r] == '0) begin
				o_rdata[r] = '0;
			end else if (i_we[1] && i_waddr[1] == i_raddr[r]) begin
				o_rdata[r] = i_wdata[1];
			end else if (i_we[0] && i_waddr[0] == i_raddr[r]) begin
				o_rdata[r] = i_wdata[0];
			end else begin
				o_rdata[r] = regs[i_raddr[r]];
			end
		end
	end

endmodule

// File: tests/cpu_core_assert.sv
`include "cpu_settings.svh"

module cpu_core_assert import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic i_stall,
	input bundle_addr_t i_addr,
	input logic [7:0] i_out_data,
	input logic i_out_vld,
	input logic i_out_rdy
);

	int fail_count = 0;

	// an edge taken in reset leaves the port idle and fetch at bundle 0
	reset_state: assert property (@(posedge clk) !rstn |=> !i_out_vld && i_addr == '0)
		else begin
			$error("output valid or fetch address not cleared by reset");
			fail_count++;
		end

	vld_held: assert property (@(posedge clk) disable iff (!rstn)
		i_out_vld && !i_out_rdy |=> i_out_vld)
		else begin
			$error("output valid dropped before the byte was accepted");
			fail_count++;
		end

	data_held: assert property (@(posedge clk) disable iff (!rstn)
		i_out_vld && !i_out_rdy |=> $stable(i_out_data))
		else begin
			$error("output data changed while waiting for ready");
			fail_count++;
		end

	addr_held: assert property (@(posedge clk) disable iff (!rstn)
		i_stall |=> $stable(i_addr))
		else begin
			$error("fetch address moved during an issue stall");
			fail_count++;
		end

endmodule

bind cpu_core cpu_core_assert u_assert (
	.clk(clk),
	.rstn(rstn),
	.i_stall(stall),
	.i_addr(o_i_addr),
	.i_out_data(o_io_out_data),
	.i_out_vld(o_io_out_vld),
	.i_out_rdy(i_io_out_rdy)
);

// File: tests/cpu_core_tb.sv
`include "cpu_settings.svh"

module cpu_core_tb import cpu_pkg::*; ();

	localparam word_t NOP = {6'h3f, 26'h0};

	logic clk;
	logic rstn;
	logic [2*`CPU_XLEN-1:0] i_rdata;
	logic i_io_out_rdy;
	bundle_addr_t o_i_addr;
	logic [7:0] o_io_out_data;
	logic o_io_out_vld;

	logic [2*`CPU_XLEN-1:0] imem [4096];
	bundle_addr_t fetch_addr;
	logic [7:0] expect_q [$];
	logic random_rdy;
	int errors;
	int checked;
	word_t a;
	word_t b;
	word_t val;

	cpu_core dut (
		.clk(clk),
		.rstn(rstn),
		.i_rdata(i_rdata),
		.i_io_out_rdy(i_io_out_rdy),
		.o_i_addr(o_i_addr),
		.o_io_out_data(o_io_out_data),
		.o_io_out_vld(o_io_out_vld)
	);

	always #10 clk = ~clk;

	// synchronous instruction memory with one cycle from address to bundle
	always @(posedge clk) begin
		fetch_addr = o_i_addr;
		#1;
		i_rdata = imem[fetch_addr];
	end

	initial begin
		void'($urandom(32448));
		i_io_out_rdy = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			i_io_out_rdy = random_rdy ? 1'($urandom % 2) : 1'b1;
		end
	end

	// a byte is taken at the edge after vld and rdy are both seen here
	always @(negedge clk) begin
		if (rstn && o_io_out_vld && i_io_out_rdy) begin
			check_byte(o_io_out_data);
		end
	end

	function automatic word_t alu_op(alu_fn_t fn, reg_addr_t dd, reg_addr_t ds, reg_addr_t dt);
		instr_u w;
		w = '0;
		w.r.opcode = `CPU_OP_ALU;
		w.r.dd = dd;
		w.r.ds = ds;
		w.r.dt = dt;
		w.r.fn = fn;
		return w;
	endfunction

	function automatic word_t imm_op(logic [5:0] opcode, reg_addr_t dd, reg_addr_t ds,
		logic [15:0] imm);
		instr_u w;
		w = '0;
		w.i.opcode = opcode;
		w.i.dd = dd;
		w.i.ds = ds;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic word_t addi_op(reg_addr_t dd, reg_addr_t ds, logic [15:0] imm);
		return imm_op(`CPU_OP_ADDI, dd, ds, imm);
	endfunction

	function automatic word_t out_op(reg_addr_t ds);
		return imm_op(`CPU_OP_OUT, '0, ds, '0);
	endfunction

	function automatic word_t jump_op(bundle_addr_t target);
		return imm_op(`CPU_OP_J, '0, '0, 16'(target));
	endfunction

	task automatic put(input int addr, input word_t slot0, input word_t slot1);
		imem[addr] = {slot0, slot1};
	endtask

	task automatic expect_byte(input word_t v);
		expect_q.push_back(v[7:0]);
	endtask

	task automatic check_byte(input logic [7:0] got);
		logic [7:0] want;
		assert (expect_q.size() > 0) else begin
			$display("unexpected byte %h appeared on the output port", got);
			errors++;
		end
		if (expect_q.size() > 0) begin
			want = expect_q.pop_front();
			checked++;
			assert (got === want) else begin
				$display("Fail o_io_out_data: got %h, expected %h", got, want);
				errors++;
			end
		end
	endtask

	// no-op words that still carry the whole address
	task automatic hold_reset();
		@(posedge clk);
		#1;
		rstn = 1'b0;
		for (int i = 0; i < 4096; i++) begin
			imem[i] = {6'h3f, 26'(i), 6'h3f, 26'(~i)};
		end
		expect_q.delete();
	endtask

	task automatic release_reset();
		repeat (16) @(posedge clk);
		#1;
		rstn = 1'b1;
	endtask

	task automatic report_test(input string name);
		$display("test %s finished, %0d errors so far", name,
			errors + dut.u_assert.fail_count);
	endtask

	task automatic wait_drained(input string name);
		int cycles;
		cycles = 0;
		while (expect_q.size() > 0 && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (expect_q.size() > 0) begin
			$display("test %s timed out with %0d bytes never sent", name, expect_q.size());
			errors++;
		end
		report_test(name);
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		i_rdata = '0;
		random_rdy = 1'b0;
		errors = 0;
		checked = 0;

		hold_reset();
		release_reset();
		@(negedge clk);
		assert (o_io_out_vld == 1'b0) else begin
			$display("Fail o_io_out_vld: got %h, expected 0", o_io_out_vld);
			errors++;
		end
		assert (o_i_addr == '0) else begin
			$display("Fail o_i_addr: got %h, expected 000", o_i_addr);
			errors++;
		end
		report_test("1 reset");

		// r0 is read while the write to it is still on the ALU output
		hold_reset();
		put(0, addi_op(1, 0, 16'h5a), addi_op(2, 0, 16'h33));
		put(1, alu_op(`CPU_FN_ADD, 3, 1, 2), alu_op(`CPU_FN_SUB, 4, 1, 2));
		put(2, alu_op(`CPU_FN_AND, 5, 1, 2), alu_op(`CPU_FN_OR, 6, 1, 2));
		put(3, alu_op(`CPU_FN_XOR, 7, 1, 2), addi_op(8, 1, 16'hfff0));
		put(4, addi_op(0, 0, 16'h55), NOP);
		put(5, out_op(0), out_op(3));
		put(6, out_op(4), out_op(5));
		put(7, out_op(6), out_op(7));
		put(8, out_op(8), NOP);
		put(9, jump_op(9), NOP);
		a = 32'h5a;
		b = 32'h33;
		expect_byte(0);
		expect_byte(a + b);
		expect_byte(a - b);
		expect_byte(a & b);
		expect_byte(a | b);
		expect_byte(a ^ b);
		expect_byte(a - 32'd16);
		release_reset();
		wait_drained("2 arithmetic");

		hold_reset();
		put(0, addi_op(1, 0, 16'h11), addi_op(2, 1, 16'h22));
		put(1, alu_op(`CPU_FN_ADD, 3, 1, 2), out_op(3));
		put(2, out_op(2), out_op(1));
		put(3, alu_op(`CPU_FN_SUB, 4, 2, 1), alu_op(`CPU_FN_XOR, 5, 4, 3));
		put(4, out_op(5), out_op(4));
		put(5, jump_op(5), NOP);
		a = 32'h11;
		b = a + 32'h22;
		expect_byte(a + b);
		expect_byte(b);
		expect_byte(a);
		expect_byte((b - a) ^ (a + b));
		expect_byte(b - a);
		release_reset();
		wait_drained("3 forwarding");

		// any byte of r2 in between means a killed slot ran
		hold_reset();
		put(0, addi_op(1, 0, 16'h71), addi_op(2, 0, 16'h72));
		put(1, jump_op(4), out_op(2));
		put(2, out_op(2), out_op(2));
		put(3, out_op(2), out_op(2));
		put(4, out_op(1), jump_op(8));
		put(5, out_op(2), out_op(2));
		put(8, addi_op(3, 1, 16'h10), NOP);
		put(9, out_op(3), NOP);
		put(10, jump_op(10), NOP);
		expect_byte(32'h71);
		expect_byte(32'h71 + 32'h10);
		release_reset();
		wait_drained("4 jumps");

		hold_reset();
		put(0, addi_op(1, 0, 16'h1), addi_op(2, 0, 16'h3));
		val = 32'h1;
		for (int k = 1; k <= 24; k++) begin
			if (k % 4 == 0) begin
				put(k, out_op(2), out_op(1));
				expect_byte(32'h3);
				expect_byte(val);
			end else begin
				put(k, out_op(1), alu_op(`CPU_FN_ADD, 1, 1, 2));
				expect_byte(val);
				val = val + 32'h3;
			end
		end
		put(25, jump_op(25), NOP);
		random_rdy = 1'b1;
		release_reset();
		wait_drained("5 back-pressure");
		random_rdy = 1'b0;

		$display("5 tests, %0d bytes checked, %0d testbench errors, %0d assertion failures",
			checked, errors, dut.u_assert.fail_count);
		if (errors + dut.u_assert.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
